// File: verilog.f
+incdir+source
source/text_pkg.sv
source/text_string_table.sv
source/glyph_rom.sv
source/text_locate.sv
source/text_pixel_out.sv
source/text_renderer.sv
test/tb_text_renderer.sv

// File: test/tb_text_renderer.sv
// Random self-checking testbench for the pixel-rate text overlay
`timescale 1ns/1ns
`include "text_macros.svh"

module tb_text_renderer;
    import text_pkg::*;

    typedef struct packed {
        logic [31:0] seq;
        logic        rst_n;
        logic        display_enable;
        coord_t      pixel_x;
        coord_t      pixel_y;
        text_cfg_t   cfg;
    } stim_t;

    logic        pixel_clk;
    logic        rst_n;
    logic        display_enable;
    coord_t      pixel_x;
    coord_t      pixel_y;
    text_cfg_t   cfg;
    color332_t   pixel_color;
    logic        pixel_visible;
    logic [31:0] seq;           // Number of the last driven pixel
    logic [31:0] last_checked;
    logic        checking;
    logic        rst_q;
    stim_t       pending[$];    // Inputs still inside the pipeline
    int          mismatches;
    int          failures;
    int          checks;
    int          visible_seen;
    int          spot_checks;
    int          run_len;
    int          max_run;

    text_renderer dut0 (
        .pixel_clk      (pixel_clk),
        .rst_n          (rst_n),
        .display_enable (display_enable),
        .pixel_x        (pixel_x),
        .pixel_y        (pixel_y),
        .cfg            (cfg),
        .pixel_color    (pixel_color),
        .pixel_visible  (pixel_visible)
    );

    initial begin
        pixel_clk = 1'b0;
        forever #2 pixel_clk = ~pixel_clk;
    end

    function automatic int str_len(input text_id_t id);
        case (id)
            TEXT_MENU:                                return 4;
            TEXT_1_PLAYER, TEXT_2_PLAYER:             return 3;
            TEXT_PRESS_BUTTON:                        return 11;
            TEXT_COUNT_3, TEXT_COUNT_2, TEXT_COUNT_1: return 1;
            default:                                  return 0;
        endcase
    endfunction

    function automatic logic blank_spot(input text_id_t id, input int index, input int row);
        if (row == 15)
            return 1'b1;
        if (id == TEXT_PRESS_BUTTON && index == 5)
            return 1'b1;  // The space
        if (id inside {TEXT_COUNT_3, TEXT_COUNT_2, TEXT_COUNT_1} && (row == 0 || row >= 12))
            return 1'b1;
        return 1'b0;
    endfunction

    // Returns 0 when no reference font row is held
    function automatic logic spot_row(input text_id_t id, input int index, input int row,
                                      output glyph_row_t bits);
        bits = '0;
        if (id == TEXT_MENU && index == 0 && row == 0)
            bits = 8'b11000011;
        else if (id == TEXT_1_PLAYER && index == 1 && (row == 7 || row == 8))
            bits = 8'hff;
        else if (id == TEXT_PRESS_BUTTON && index == 7 && row == 0)
            bits = 8'hff;
        else if (id == TEXT_COUNT_3 && index == 0 && row == 1)
            bits = 8'b01111110;
        else
            return 1'b0;
        return 1'b1;
    endfunction

    task automatic check_output(input stim_t s);
        int         rel_x;
        int         rel_y;
        int         index;
        int         row;
        int         col;
        logic       hit;
        logic       known;
        logic       exp_vis;
        glyph_row_t bits;
        color332_t  exp_color;
        rel_x = int'(s.pixel_x) - int'(s.cfg.x_pos);
        rel_y = int'(s.pixel_y) - int'(s.cfg.y_pos);
        hit   = s.rst_n && s.display_enable && s.cfg.enable && rel_x >= 0 && rel_y >= 0 &&
                rel_x < `TEXT_CHAR_WIDTH * str_len(s.cfg.id) && rel_y < `TEXT_CHAR_HEIGHT;
        index = rel_x / `TEXT_CHAR_WIDTH;
        col   = rel_x % `TEXT_CHAR_WIDTH;
        row   = rel_y % `TEXT_CHAR_HEIGHT;
        known   = 1'b1;
        exp_vis = 1'b0;
        if (hit && !blank_spot(s.cfg.id, index, row)) begin
            known   = spot_row(s.cfg.id, index, row, bits);
            exp_vis = bits[7 - col];
            if (known)
                spot_checks++;
        end
        checks++;
        if ($isunknown({pixel_visible, pixel_color})) begin
            failures++;
            $display("outputs carry unknown bits at %0t", $time);
        end
        if (known && pixel_visible !== exp_vis) begin
            mismatches++;
            $display("mismatch at %0t: pixel_visible got %b expected %b (x %0d y %0d id %0d)",
                     $time, pixel_visible, exp_vis, s.pixel_x, s.pixel_y, s.cfg.id);
        end
        if (pixel_visible === 1'b1 && !hit) begin
            failures++;
            $display("pixel shown outside the text box at %0t (x %0d y %0d)",
                     $time, s.pixel_x, s.pixel_y);
        end
        exp_color = ((known ? exp_vis : pixel_visible) === 1'b1) ? s.cfg.color : '0;
        if (pixel_color !== exp_color) begin
            mismatches++;
            $display("mismatch at %0t: pixel_color got %h expected %h",
                     $time, pixel_color, exp_color);
        end
        last_checked = s.seq;
    endtask

    // Outputs are sampled on the falling edge
    always @(negedge pixel_clk) begin
        if (checking) begin
            if ((!rst_n || !rst_q) && pixel_visible !== 1'b0) begin
                failures++;
                $display("pixel_visible not low during or just after reset at %0t", $time);
            end
            if (pending.size() == 2)
                check_output(pending.pop_front());
            pending.push_back(stim_t'{seq, rst_n, display_enable, pixel_x, pixel_y, cfg});
            run_len = (pixel_visible === 1'b1) ? run_len + 1 : 0;
            if (run_len > max_run)
                max_run = run_len;
            if (pixel_visible === 1'b1)
                visible_seen++;
            rst_q = rst_n;
        end
    end

    task automatic drive_pixel(input int x, input int y, input logic de);
        @(posedge pixel_clk);
        pixel_x        <= coord_t'(x);
        pixel_y        <= coord_t'(y);
        display_enable <= de;
        seq            <= seq + 1;
    endtask

    task automatic set_config(input text_id_t id, input logic en, input int x, input int y);
        text_cfg_t c;
        c.enable = en;
        c.x_pos  = coord_t'(x);
        c.y_pos  = coord_t'(y);
        c.color  = color332_t'($urandom);
        c.id     = id;
        @(posedge pixel_clk);
        cfg <= c;
    endtask

    task automatic random_step();
        int       r;
        int       x0;
        int       y0;
        int       len;
        int       xs[4];
        int       ys[4];
        text_id_t id;
        r  = $urandom_range(9);
        id = (r < 8) ? text_id_t'(r % 7) : text_id_t'($urandom_range(15, 7));
        x0 = $urandom_range(600);
        y0 = $urandom_range(600);
        set_config(id, $urandom_range(9) != 0, x0, y0);
        len = `TEXT_CHAR_WIDTH * str_len(id);
        xs  = '{x0 - 1, x0, x0 + len - 1, x0 + len};  // Just outside and inside each edge
        ys  = '{y0 - 1, y0, y0 + 15, y0 + 16};
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                drive_pixel(xs[i], ys[j], 1'b1);
            end
        end
        for (int k = 0; k < 40; k++) begin
            drive_pixel(x0 - 8 + $urandom_range(len + 15), y0 - 2 + $urandom_range(19),
                        $urandom_range(9) != 0);
        end
    endtask

    task automatic scan_cell(input text_id_t id, input int index);
        int x0;
        int y0;
        x0 = $urandom_range(500);
        y0 = $urandom_range(500);
        set_config(id, 1'b1, x0, y0);
        for (int r = 0; r < `TEXT_CHAR_HEIGHT; r++) begin
            for (int c = 0; c < `TEXT_CHAR_WIDTH; c++) begin
                drive_pixel(x0 + index * `TEXT_CHAR_WIDTH + c, y0 + r, 1'b1);
            end
        end
    endtask

    task automatic wait_for_run(input int length);
        int cycles;
        cycles = 0;
        while (max_run < length && cycles < 20) begin
            @(posedge pixel_clk);
            cycles++;
        end
        if (max_run < length) begin
            failures++;
            $display("steady hit stream left gaps, longest run %0d of %0d", max_run, length);
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (last_checked != seq && cycles < 16) begin
            @(posedge pixel_clk);
            cycles++;
        end
        if (last_checked != seq) begin
            failures++;
            $display("pipeline did not return the last driven pixel in time");
        end
    endtask

    initial begin
        void'($urandom(22208));
        rst_n          = 1'b0;
        display_enable = 1'b1;
        pixel_x        = '0;
        pixel_y        = '0;
        cfg            = '{enable: 1'b1, x_pos: '0, y_pos: '0,
                           color: 8'hff, id: TEXT_MENU};  // Lit MENU pixel held in reset
        seq            = '0;
        last_checked   = '0;
        checking       = 1'b0;
        rst_q          = 1'b0;
        mismatches     = 0;
        failures       = 0;
        checks         = 0;
        visible_seen   = 0;
        spot_checks    = 0;
        run_len        = 0;
        max_run        = 0;
        @(posedge pixel_clk);
        checking <= 1'b1;
        repeat (7) @(posedge pixel_clk);
        rst_n <= 1'b1;
        repeat (150) random_step();
        scan_cell(TEXT_MENU, 0);
        scan_cell(TEXT_1_PLAYER, 1);
        scan_cell(TEXT_PRESS_BUTTON, 5);
        scan_cell(TEXT_COUNT_3, 0);
        scan_cell(TEXT_COUNT_2, 0);
        scan_cell(TEXT_COUNT_1, 0);
        scan_cell(text_id_t'(4'd7), 0);  // Unknown id
        max_run = 0;
        scan_cell(TEXT_PRESS_BUTTON, 7);  // Row 0 is eight lit pixels in a row
        wait_for_run(`TEXT_CHAR_WIDTH);
        wait_drain();
        if (visible_seen == 0 || spot_checks == 0) begin
            failures++;
            $display("no visible text pixels were produced");
        end
        $display("checks %0d, spot checks %0d, mismatches %0d, other failures %0d",
                 checks, spot_checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: source/text_renderer.sv
// Pixel-rate text overlay with a fixed two-cycle locate and glyph pipeline
`timescale 1ns/1ns

module text_renderer (
    input  logic                pixel_clk,
    input  logic                rst_n,
    input  logic                display_enable,
    input  text_pkg::coord_t    pixel_x,
    input  text_pkg::coord_t    pixel_y,
    input  text_pkg::text_cfg_t cfg,
    output text_pkg::color332_t pixel_color,
    output logic                pixel_visible
);
    import text_pkg::*;

    glyph_req_t req;  // Locate to glyph stage

    // Cycle 1 finds which character cell the pixel falls in
    text_locate u_text_locate (
        .pixel_clk      (pixel_clk),
        .rst_n          (rst_n),
        .display_enable (display_enable),
        .pixel_x        (pixel_x),
        .pixel_y        (pixel_y),
        .cfg            (cfg),
        .req            (req)
    );

    // Cycle 2 reads the font bit and forms the output
    text_pixel_out u_text_pixel_out (
        .pixel_clk     (pixel_clk),
        .rst_n         (rst_n),
        .req           (req),
        .pixel_color   (pixel_color),
        .pixel_visible (pixel_visible)
    );

endmodule

// File: source/text_pixel_out.sv
// Second overlay stage that looks up the glyph bit and registers colour and visibility
`timescale 1ns/1ns

module text_pixel_out (
    input  logic                 pixel_clk,
    input  logic                 rst_n,
    input  text_pkg::glyph_req_t req,
    output text_pkg::color332_t  pixel_color,
    output logic                 pixel_visible
);
    import text_pkg::*;

    glyph_row_t row_bits;
    logic       visible_next;

    glyph_rom u_glyph_rom (
        .code (req.code),
        .row  (req.row),
        .bits (row_bits)
    );

    assign visible_next = req.hit && row_bits[3'd7 - req.col];  // Column 0 is bit 7

    always_ff @(posedge pixel_clk) begin
        if (!rst_n) begin
            pixel_visible <= 1'b0;
            pixel_color   <= '0;
        end else begin
            pixel_visible <= visible_next;
            pixel_color   <= visible_next ? req.color : '0;
        end
    end

    // Transparent pixels carry black so downstream mixing can OR layers
    assert property (@(posedge pixel_clk) !pixel_visible |-> pixel_color == '0);

    // No pixel located during reset reaches the output
    assert property (@(posedge pixel_clk) $rose(rst_n) |=> !pixel_visible);

endmodule

// File: source/text_locate.sv
// First overlay stage that bounds-checks the pixel and registers its glyph position
`timescale 1ns/1ns
`include "text_macros.svh"

module text_locate (
    input  logic                 pixel_clk,
    input  logic                 rst_n,
    input  logic                 display_enable,
    input  text_pkg::coord_t     pixel_x,
    input  text_pkg::coord_t     pixel_y,
    input  text_pkg::text_cfg_t  cfg,
    output text_pkg::glyph_req_t req
);
    import text_pkg::*;

    // One spare bit so the right and bottom edges never wrap
    localparam int END_BITS = `TEXT_COORD_BITS + 1;

    coord_t              rel_x;
    coord_t              rel_y;
    logic [3:0]          char_index;
    char_code_t          code;
    logic [3:0]          length;
    logic [END_BITS-1:0] x_end;
    logic [END_BITS-1:0] y_end;
    logic                hit;

    assign rel_x      = pixel_x - cfg.x_pos;
    assign rel_y      = pixel_y - cfg.y_pos;
    assign char_index = 4'(rel_x / `TEXT_CHAR_WIDTH);

    text_string_table u_text_string_table (
        .id     (cfg.id),
        .index  (char_index),
        .code   (code),
        .length (length)
    );

    assign x_end = {1'b0, cfg.x_pos} + END_BITS'(length * `TEXT_CHAR_WIDTH);
    assign y_end = {1'b0, cfg.y_pos} + END_BITS'(`TEXT_CHAR_HEIGHT);

    assign hit = cfg.enable && display_enable &&
                 (pixel_x >= cfg.x_pos) && ({1'b0, pixel_x} < x_end) &&
                 (pixel_y >= cfg.y_pos) && ({1'b0, pixel_y} < y_end);

    always_ff @(posedge pixel_clk) begin
        if (!rst_n) begin
            req.hit <= 1'b0;
        end else begin
            req.hit <= hit;
        end
        req.code  <= code;
        req.row   <= 4'(rel_y % `TEXT_CHAR_HEIGHT);
        req.col   <= 3'(rel_x % `TEXT_CHAR_WIDTH);
        req.color <= cfg.color;
    end

    // A registered hit always traces back to a drawable string
    assert property (@(posedge pixel_clk) disable iff (!rst_n)
        req.hit |-> $past(cfg.id) inside {TEXT_MENU, TEXT_1_PLAYER, TEXT_2_PLAYER,
                                          TEXT_PRESS_BUTTON, TEXT_COUNT_3,
                                          TEXT_COUNT_2, TEXT_COUNT_1});

endmodule

// File: source/glyph_rom.sv
// Bitmap font of 8x16 glyphs addressed by character code and row
`timescale 1ns/1ns

module glyph_rom (
    input  text_pkg::char_code_t code,
    input  logic [3:0]           row,
    output text_pkg::glyph_row_t bits
);
    import text_pkg::*;

    always_comb begin
        bits = '0;  // Rows not listed are blank
        case (code)
            CH_M: begin
                case (row) inside
                    4'd0:          bits = 8'b11000011;
                    4'd1:          bits = 8'b11100111;
                    4'd2:          bits = 8'b11111111;
                    4'd3:          bits = 8'b11011011;
                    [4'd4:4'd14]:  bits = 8'b11000011;
                endcase
            end
            CH_E: begin
                case (row) inside
                    4'd0:          bits = 8'b11111111;
                    [4'd1:4'd3]:   bits = 8'b11000000;
                    4'd4:          bits = 8'b11111110;
                    [4'd5:4'd13]:  bits = 8'b11000000;
                    4'd14:         bits = 8'b11111111;
                endcase
            end
            CH_N: begin
                case (row) inside
                    4'd0:          bits = 8'b11000011;
                    4'd1:          bits = 8'b11100011;
                    4'd2:          bits = 8'b11110011;
                    4'd3:          bits = 8'b11111011;
                    4'd4:          bits = 8'b11011111;
                    4'd5:          bits = 8'b11001111;
                    4'd6:          bits = 8'b11000111;
                    [4'd7:4'd14]:  bits = 8'b11000011;
                endcase
            end
            CH_U: begin
                case (row) inside
                    [4'd0:4'd11]:  bits = 8'b11000011;
                    4'd12:         bits = 8'b01100110;
                    4'd13:         bits = 8'b00111100;
                    4'd14:         bits = 8'b00011000;
                endcase
            end
            CH_P: begin
                case (row) inside
                    4'd0:          bits = 8'b11111110;
                    [4'd1:4'd3]:   bits = 8'b11000011;
                    4'd4:          bits = 8'b11111110;
                    [4'd5:4'd14]:  bits = 8'b11000000;
                endcase
            end
            CH_R: begin
                case (row) inside
                    4'd0:          bits = 8'b11111110;
                    [4'd1:4'd3]:   bits = 8'b11000011;
                    4'd4:          bits = 8'b11111110;
                    4'd5:          bits = 8'b11111000;
                    4'd6:          bits = 8'b11001100;
                    4'd7:          bits = 8'b11000110;
                    [4'd8:4'd14]:  bits = 8'b11000011;
                endcase
            end
            CH_S: begin
                case (row) inside
                    4'd0:          bits = 8'b01111110;
                    4'd1:          bits = 8'b11000011;
                    [4'd2:4'd3]:   bits = 8'b11000000;
                    4'd4:          bits = 8'b01111110;
                    [4'd5:4'd10]:  bits = 8'b00000011;
                    4'd11:         bits = 8'b11000011;
                    4'd12:         bits = 8'b01111110;
                endcase
            end
            CH_T: begin
                case (row) inside
                    4'd0:          bits = 8'b11111111;
                    [4'd1:4'd14]:  bits = 8'b00011000;
                endcase
            end
            CH_A: begin
                case (row) inside
                    4'd0:          bits = 8'b00111100;
                    4'd1:          bits = 8'b01100110;
                    [4'd2:4'd4]:   bits = 8'b11000011;
                    4'd5:          bits = 8'b11111111;
                    [4'd6:4'd14]:  bits = 8'b11000011;
                endcase
            end
            CH_DASH: begin
                case (row) inside
                    [4'd7:4'd8]:   bits = 8'b11111111;
                endcase
            end
            CH_ONE: begin
                case (row) inside
                    4'd0:          bits = 8'b00011000;
                    4'd1:          bits = 8'b00111000;
                    [4'd2:4'd13]:  bits = 8'b00011000;
                    4'd14:         bits = 8'b01111110;
                endcase
            end
            CH_TWO: begin
                case (row) inside
                    4'd0:          bits = 8'b01111110;
                    4'd1:          bits = 8'b11000011;
                    [4'd2:4'd3]:   bits = 8'b00000011;
                    4'd4:          bits = 8'b00000110;
                    4'd5:          bits = 8'b00001100;
                    4'd6:          bits = 8'b00011000;
                    4'd7:          bits = 8'b00110000;
                    4'd8:          bits = 8'b01100000;
                    [4'd9:4'd11]:  bits = 8'b11000000;
                    [4'd12:4'd13]: bits = 8'b11000011;
                    4'd14:         bits = 8'b11111111;
                endcase
            end
            // Countdown digits sit in rows 1 to 11
            CH_CNT_ONE: begin
                case (row) inside
                    4'd1:          bits = 8'b00011000;
                    4'd2:          bits = 8'b00111000;
                    [4'd3:4'd10]:  bits = 8'b00011000;
                    4'd11:         bits = 8'b01111110;
                endcase
            end
            CH_CNT_TWO: begin
                case (row) inside
                    4'd1:          bits = 8'b01111110;
                    4'd2:          bits = 8'b11000011;
                    4'd3:          bits = 8'b00000011;
                    4'd4:          bits = 8'b00000110;
                    4'd5:          bits = 8'b00001100;
                    4'd6:          bits = 8'b00011000;
                    4'd7:          bits = 8'b00110000;
                    4'd8:          bits = 8'b01100000;
                    4'd9:          bits = 8'b11000000;
                    4'd10:         bits = 8'b11000011;
                    4'd11:         bits = 8'b11111111;
                endcase
            end
            CH_CNT_THREE: begin
                case (row) inside
                    4'd1:          bits = 8'b01111110;
                    4'd2:          bits = 8'b11000011;
                    [4'd3:4'd4]:   bits = 8'b00000011;
                    4'd5:          bits = 8'b00111110;
                    [4'd6:4'd10]:  bits = 8'b00000011;
                    4'd11:         bits = 8'b11000011;
                endcase
            end
            default: bits = '0;  // CH_BLANK
        endcase
    end

endmodule

// File: source/text_string_table.sv
// Character sequence and length of each overlay string
`timescale 1ns/1ns
`include "text_macros.svh"

module text_string_table (
    input  text_pkg::text_id_t   id,
    input  logic [3:0]           index,
    output text_pkg::char_code_t code,
    output logic [3:0]           length
);
    import text_pkg::*;

    always_comb begin
        code   = CH_BLANK;
        length = 4'd0;
        case (id)
            TEXT_MENU: begin
                length = 4'd4;
                case (index)
                    4'd0: code = CH_M;
                    4'd1: code = CH_E;
                    4'd2: code = CH_N;
                    4'd3: code = CH_U;
                    default: code = CH_BLANK;
                endcase
            end
            TEXT_1_PLAYER, TEXT_2_PLAYER: begin
                length = 4'd3;
                case (index)
                    4'd0: code = (id == TEXT_1_PLAYER) ? CH_ONE : CH_TWO;
                    4'd1: code = CH_DASH;
                    4'd2: code = CH_P;
                    default: code = CH_BLANK;
                endcase
            end
            TEXT_PRESS_BUTTON: begin
                length = 4'(`TEXT_MAX_CHARS);
                case (index)
                    4'd0: code = CH_P;
                    4'd1: code = CH_R;
                    4'd2: code = CH_E;
                    4'd3, 4'd4, 4'd6: code = CH_S;
                    4'd7, 4'd10: code = CH_T;
                    4'd8: code = CH_A;
                    4'd9: code = CH_R;
                    default: code = CH_BLANK;  // Index 5 is the space
                endcase
            end
            TEXT_COUNT_3: begin
                length = 4'd1;
                code   = (index == 4'd0) ? CH_CNT_THREE : CH_BLANK;
            end
            TEXT_COUNT_2: begin
                length = 4'd1;
                code   = (index == 4'd0) ? CH_CNT_TWO : CH_BLANK;
            end
            TEXT_COUNT_1: begin
                length = 4'd1;
                code   = (index == 4'd0) ? CH_CNT_ONE : CH_BLANK;
            end
            default: length = 4'd0;  // Unknown id draws nothing
        endcase
    end

endmodule

// File: source/text_pkg.sv
// Text overlay types shared by the locate stage, glyph stage and string tables
`include "text_macros.svh"

package text_pkg;

    typedef logic [`TEXT_COORD_BITS-1:0] coord_t;
    typedef logic [7:0] color332_t;   // RRR GGG BB
    typedef logic [7:0] glyph_row_t;  // Bit 7 is the leftmost pixel

    typedef enum logic [3:0] {
        TEXT_MENU         = 4'd0,
        TEXT_1_PLAYER     = 4'd1,
        TEXT_2_PLAYER     = 4'd2,
        TEXT_PRESS_BUTTON = 4'd3,
        TEXT_COUNT_3      = 4'd4,
        TEXT_COUNT_2      = 4'd5,
        TEXT_COUNT_1      = 4'd6
    } text_id_t;

    // One entry per distinct glyph in the font
    typedef enum logic [3:0] {
        CH_BLANK,
        CH_A,
        CH_E,
        CH_M,
        CH_N,
        CH_P,
        CH_R,
        CH_S,
        CH_T,
        CH_U,
        CH_DASH,
        CH_ONE,
        CH_TWO,
        CH_CNT_ONE,   // Large countdown digits
        CH_CNT_TWO,
        CH_CNT_THREE
    } char_code_t;

    typedef struct packed {
        logic      enable;
        coord_t    x_pos;   // Top-left corner
        coord_t    y_pos;
        color332_t color;
        text_id_t  id;
    } text_cfg_t;

    typedef struct packed {
        logic       hit;
        char_code_t code;
        logic [3:0] row;
        logic [2:0] col;
        color332_t  color;
    } glyph_req_t;

endpackage

// File: source/text_macros.svh
// Font geometry and coordinate sizing for the pixel-rate text overlay
`ifndef TEXT_MACROS_SVH
`define TEXT_MACROS_SVH

// Glyph cell is 8 pixels wide and 16 rows tall
`define TEXT_CHAR_WIDTH  8
`define TEXT_CHAR_HEIGHT 16

// Screen coordinates up to 1023
`define TEXT_COORD_BITS  10

// PRESS START is the longest string
`define TEXT_MAX_CHARS   11

`endif
